//--- bench/mmc_mailbox_tb.sv
`timescale 1ns/10ps
module mmc_mailbox_tb;

  typedef enum int {k_spi, k_lbwr, k_lbrd, k_port, k_stat} kind_e;
  typedef enum logic [10:0] {
    s_enable_rx, s_ip_valid, s_mac_valid, s_gitid_valid, s_match,
    s_ip, s_mac_lo, s_mac_hi, s_gitid
  } status_e;
  typedef struct {
    kind_e       kind;
    logic [15:0] value;     // SPI word or lb data in the low byte
    logic [10:0] addr;      // lb address, port index or status select
    logic [31:0] expected;
  } entry_t;

  localparam logic [31:0]  build_hash    = 32'h5a1b2c3d;
  localparam logic         rx_default    = 1'b0;
  localparam logic [127:0] port_defaults = {16'd8017, 16'd8016, 16'd8015, 16'd8014,
                                            16'd8013, 16'd8012, 16'd8011, 16'd8010};

  logic        clk;
  logic        rst_n;
  logic [10:0] lb_addr;
  logic [7:0]  lb_din;
  logic        lb_write;
  logic        lb_control_strobe;
  logic [7:0]  lb_dout;
  // SPI pins
  logic        sck;
  logic        ncs;
  logic        pico;
  logic        poci;
  logic [10:0] mb_addr;
  logic        mb_wen;
  logic        mb_ren;
  logic        mb_strobe;
  logic [2:0]  pno_a;
  logic [15:0] pno_d;
  logic        enable_rx;
  logic        ip_valid;
  logic        mac_valid;
  logic        gitid_valid;
  logic        match;
  logic [31:0] ip;
  logic [47:0] mac;
  logic [31:0] gitid;
  entry_t      tbl [$];
  int          errors;
  int          checks;
  int          timeouts;
  int          ren_count;
  int          wen_count;
  int          strb_count;
  logic [10:0] ren_addr;
  logic [10:0] wen_addr;
  logic [6:0]  page_model;  // Last page selected over SPI

  mmc_mailbox #(
    .hash              (build_hash),
    .default_enable_rx (rx_default),
    .udp_ports         (port_defaults)
  ) dut (.*);

  always #5 clk = ~clk;

  // Port-1 pulses seen on the mirror outputs
  always @(negedge clk) begin
    if (mb_ren) begin
      ren_count++;
      ren_addr = mb_addr;
    end
    if (mb_wen) begin
      wen_count++;
      wen_addr = mb_addr;
    end
    if (mb_strobe) strb_count++;
  end

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] got);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, expected, got);
    end
  endtask

  task automatic add(input kind_e kind, input logic [15:0] value, input logic [10:0] addr,
                     input logic [31:0] expected);
    entry_t e;
    e.kind     = kind;
    e.value    = value;
    e.addr     = addr;
    e.expected = expected;
    tbl.push_back(e);
  endtask

  // Mode 0 host with 20 clk per half period
  // poci is read just before each rising edge
  task automatic spi_xfer(input logic [15:0] word, output logic [15:0] rx);
    int n;
    @(posedge clk);
    ncs <= 1'b0;
    repeat (20) @(posedge clk);
    for (int i = 15; i >= 0; i--) begin
      @(posedge clk);
      sck  <= 1'b0;
      pico <= word[i];
      repeat (19) @(posedge clk);
      @(negedge clk);
      rx[i] = poci;
      @(posedge clk);
      sck <= 1'b1;
      repeat (19) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;
    repeat (20) @(posedge clk);
    ncs <= 1'b1;
    @(negedge clk);
    n = 1;
    while (!mb_strobe && n < 50) begin  // Word strobe follows ncs by a few clk
      @(negedge clk);
      n++;
    end
    if (!mb_strobe) begin
      timeouts++;
      $display("timeout at %0t ns: no mb_strobe after SPI word %h", $time, word);
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic lb_wr(input logic [10:0] a, input logic [7:0] d);
    @(posedge clk);
    lb_addr           <= a;
    lb_din            <= d;
    lb_write          <= 1'b1;
    lb_control_strobe <= 1'b1;
    @(posedge clk);
    lb_write          <= 1'b0;
    lb_control_strobe <= 1'b0;
  endtask

  task automatic lb_rd(input logic [10:0] a, input logic [31:0] expected);
    @(posedge clk);
    lb_addr           <= a;
    lb_write          <= 1'b0;
    lb_control_strobe <= 1'b1;
    @(posedge clk);
    lb_control_strobe <= 1'b0;
    @(posedge clk);  // Second clk after the strobe
    @(negedge clk);
    check("lb_dout", expected, 32'(lb_dout));
  endtask

  task automatic probe_status(input status_e sel, input logic [31:0] expected);
    @(negedge clk);
    case (sel)
      s_enable_rx:   check("enable_rx", expected, 32'(enable_rx));
      s_ip_valid:    check("ip_valid", expected, 32'(ip_valid));
      s_mac_valid:   check("mac_valid", expected, 32'(mac_valid));
      s_gitid_valid: check("gitid_valid", expected, 32'(gitid_valid));
      s_match:       check("match", expected, 32'(match));
      s_ip:          check("ip", expected, ip);
      s_mac_lo:      check("mac[31:0]", expected, mac[31:0]);
      s_mac_hi:      check("mac[47:32]", expected, 32'(mac[47:32]));
      default:       check("gitid", expected, gitid);
    endcase
  endtask

  task automatic apply(input entry_t e);
    logic [15:0] rx;
    int          ren0;
    int          wen0;
    int          strb0;
    case (e.kind)
      k_spi: begin
        ren0  = ren_count;
        wen0  = wen_count;
        strb0 = strb_count;
        spi_xfer(e.value, rx);
        check("poci word", e.expected, 32'(rx));
        check("mb_strobe pulses", 32'd1, 32'(strb_count - strb0));
        check("mb_ren pulses", 32'(e.value[15:12] == 4'h4), 32'(ren_count - ren0));
        check("mb_wen pulses", 32'(e.value[15:12] == 4'h5), 32'(wen_count - wen0));
        if (e.value[15:12] == 4'h4)
          check("mb_addr on read", 32'({page_model, e.value[11:8]}), 32'(ren_addr));
        if (e.value[15:12] == 4'h5)
          check("mb_addr on write", 32'({page_model, e.value[11:8]}), 32'(wen_addr));
        if (e.value[15:8] == 8'h22) page_model = e.value[6:0];  // Page select
      end
      k_lbwr: lb_wr(e.addr, e.value[7:0]);
      k_lbrd: lb_rd(e.addr, e.expected);
      k_port: begin
        @(posedge clk);
        pno_a <= e.addr[2:0];
        @(negedge clk);
        check("pno_d", e.expected, 32'(pno_d));
      end
      default: probe_status(status_e'(e.addr), e.expected);
    endcase
  endtask

  task automatic build_table();
    logic [7:0]  ipb [10];
    logic [7:0]  gid [4];
    logic [7:0]  hsb [4];
    logic [7:0]  mbd;
    logic [7:0]  lbd;
    logic [15:0] port;
    for (int i = 0; i < 10; i++) ipb[i] = 8'($urandom());
    for (int k = 0; k < 4; k++) begin
      gid[k] = 8'($urandom());
      hsb[k] = build_hash[31 - 8 * k -: 8];  // Offset 12 holds the MSB
    end
    mbd  = 8'($urandom());
    lbd  = 8'($urandom());
    port = 16'($urandom());
    // Reset values
    add(k_stat, '0, s_enable_rx, 32'(rx_default));
    for (int s = 1; s <= 4; s++) add(k_stat, '0, 11'(s), '0);  // Valid flags, match
    for (int i = 0; i < 8; i++) add(k_port, '0, 11'(i), 32'(port_defaults[16 * i +: 16]));
    // Byte 0 goes first since it restarts the IP/MAC set
    for (int i = 0; i < 10; i++) add(k_spi, {4'h1, 4'(i), ipb[i]}, '0, '0);
    add(k_stat, '0, s_mac_valid, 32'd1);
    add(k_stat, '0, s_ip_valid, 32'd1);
    add(k_stat, '0, s_ip, {ipb[9], ipb[8], ipb[7], ipb[6]});
    add(k_stat, '0, s_mac_lo, {ipb[3], ipb[2], ipb[1], ipb[0]});
    add(k_stat, '0, s_mac_hi, {16'h0, ipb[5], ipb[4]});
    add(k_spi, {8'h10, ~ipb[0]}, '0, '0);
    add(k_stat, '0, s_ip_valid, '0);
    // Page 0x15 traffic both ways between SPI and local bus
    add(k_spi, 16'h2215, '0, '0);
    add(k_spi, {8'h57, mbd}, '0, '0);
    add(k_lbrd, '0, 11'(8'h15 * 16 + 7), {24'h0, mbd});
    add(k_lbwr, {8'h0, lbd}, 11'(8'h15 * 16 + 10), '0);
    add(k_spi, 16'h4a00, '0, {24'h0, lbd});
    add(k_spi, 16'h4700, '0, {24'h0, mbd});
    // Git ID window on page 3 and hash window on page 4
    add(k_spi, 16'h2203, '0, '0);
    for (int k = 0; k < 4; k++) add(k_spi, {4'h5, 4'(12 + k), gid[k]}, '0, '0);
    add(k_spi, 16'h2204, '0, '0);
    for (int k = 0; k < 4; k++) add(k_spi, {4'h5, 4'(12 + k), hsb[k]}, '0, '0);
    add(k_stat, '0, s_gitid_valid, 32'd1);
    add(k_stat, '0, s_gitid, {gid[0], gid[1], gid[2], gid[3]});
    add(k_stat, '0, s_match, 32'd1);
    add(k_spi, {8'h5f, hsb[3] ^ 8'h01}, '0, '0);  // One bad hash bit
    add(k_stat, '0, s_match, '0);
    add(k_spi, {8'h5f, hsb[3]}, '0, '0);
    // Same offsets on page 5 hit no window
    add(k_spi, 16'h2205, '0, '0);
    for (int k = 0; k < 4; k++) add(k_spi, {4'h5, 4'(12 + k), ~gid[k]}, '0, '0);
    add(k_stat, '0, s_gitid, {gid[0], gid[1], gid[2], gid[3]});
    add(k_stat, '0, s_match, 32'd1);
    // UDP entry 2 with the low byte at the even address
    add(k_spi, {8'h34, port[7:0]}, '0, '0);
    add(k_spi, {8'h35, port[15:8]}, '0, '0);
    for (int i = 1; i < 4; i++)
      add(k_port, '0, 11'(i), (i == 2) ? 32'(port) : 32'(port_defaults[16 * i +: 16]));
    add(k_spi, 16'h2001, '0, '0);
    add(k_stat, '0, s_enable_rx, 32'd1);
    add(k_spi, 16'h2000, '0, '0);
    add(k_stat, '0, s_enable_rx, '0);
  endtask

  initial begin
    clk               = 1'b0;
    rst_n             = 1'b0;
    lb_addr           = '0;
    lb_din            = '0;
    lb_write          = 1'b0;
    lb_control_strobe = 1'b0;
    sck               = 1'b0;
    ncs               = 1'b1;  // Deselected
    pico              = 1'b0;
    pno_a             = '0;
    errors            = 0;
    checks            = 0;
    timeouts          = 0;
    ren_count         = 0;
    wen_count         = 0;
    strb_count        = 0;
    ren_addr          = '0;
    wen_addr          = '0;
    page_model        = '0;
    void'($urandom(37));
    build_table();
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tbl[i]) begin
      if (timeouts == 0) apply(tbl[i]);  // Stop at the first hung word
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- mmc_mailbox.f
rtl/mbox_map_pkg.sv
rtl/spi_cmd_pkg.sv
rtl/spi_word_rx.sv
rtl/mbox_dpram.sv
rtl/mbox_cfg_regs.sv
rtl/udp_port_table.sv
rtl/mmc_mailbox.sv
bench/mmc_mailbox_tb.sv

//--- rtl/mbox_cfg_regs.sv
`timescale 1ns/10ps
module mbox_cfg_regs #(
  parameter mbox_map_pkg::word32_t hash = '0,
  parameter logic default_enable_rx = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cfg_w,
  input  spi_cmd_pkg::cfg_addr_t     cfg_a,
  input  mbox_map_pkg::byte_t        cfg_d,
  output mbox_map_pkg::mbox_page_t   page,
  output logic                       enable_rx,
  output logic                       ip_valid,
  output mbox_map_pkg::word32_t      ip,
  output logic                       mac_valid,
  output logic [47:0]                mac,
  output logic                       gitid_valid,
  output mbox_map_pkg::word32_t      gitid,
  output logic                       match
);

  spi_cmd_pkg::cmd_group_e   grp;
  mbox_map_pkg::mbox_off_t   off;
  mbox_map_pkg::byte_t       ipmac [16];
  logic [15:0]               ipmac_vld;  // One bit per byte
  logic                      ipmac_wr;
  logic                      mb_wr;
  mbox_map_pkg::mbox_off_t   gid_rel;    // Offset within window
  mbox_map_pkg::mbox_off_t   hsh_rel;
  logic                      gid_hit;
  logic                      hsh_hit;
  logic [3:0]                gid_vld;
  logic [3:0]                hsh_vld;
  mbox_map_pkg::word32_t     hash_r;

  // Byte 0 restarts the set, others add to it
  function automatic logic [3:0] mark_valid(logic [3:0] cur, logic [1:0] idx);
    logic [3:0] res;
    res = cur;
    if (idx == 2'd0) res = 4'b0001;
    else res[idx] = 1'b1;
    return res;
  endfunction

  assign grp      = spi_cmd_pkg::cmd_group_e'(cfg_a[7:4]);
  assign off      = cfg_a[3:0];
  assign ipmac_wr = cfg_w && (grp == spi_cmd_pkg::grp_ipmac);
  assign mb_wr    = cfg_w && (grp == spi_cmd_pkg::grp_mb_write);

  // Wraps below the window, so < 4 covers the four bytes only
  assign gid_rel = off - mbox_map_pkg::gitid_offset;
  assign hsh_rel = off - mbox_map_pkg::hash_offset;
  // Not exclusive, both windows may share a page
  assign gid_hit = mb_wr && (page == mbox_map_pkg::gitid_page) && (gid_rel < 4'd4);
  assign hsh_hit = mb_wr && (page == mbox_map_pkg::hash_page) && (hsh_rel < 4'd4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_rx <= default_enable_rx;
      page      <= '0;
      ipmac_vld <= '0;
      gid_vld   <= '0;
      hsh_vld   <= '0;
    end else begin
      if (cfg_w && cfg_a == spi_cmd_pkg::addr_enable_rx) enable_rx <= cfg_d[0];
      if (cfg_w && cfg_a == spi_cmd_pkg::addr_page_sel) page <= cfg_d[6:0];
      if (ipmac_wr) begin
        if (off == 4'd0) ipmac_vld <= 16'h0001;
        else ipmac_vld[off] <= 1'b1;
      end
      if (gid_hit) gid_vld <= mark_valid(gid_vld, gid_rel[1:0]);
      if (hsh_hit) hsh_vld <= mark_valid(hsh_vld, hsh_rel[1:0]);
    end
  end

  // Byte lanes, ~idx is 3-idx for big-endian
  always_ff @(posedge clk) begin
    if (ipmac_wr) ipmac[off] <= cfg_d;
    if (gid_hit) gitid[{~gid_rel[1:0], 3'b000} +: 8] <= cfg_d;
    if (hsh_hit) hash_r[{~hsh_rel[1:0], 3'b000} +: 8] <= cfg_d;
  end

  assign ip          = {ipmac[9], ipmac[8], ipmac[7], ipmac[6]};
  assign ip_valid    = &ipmac_vld[9:6];
  assign mac         = {ipmac[5], ipmac[4], ipmac[3], ipmac[2], ipmac[1], ipmac[0]};
  assign mac_valid   = &ipmac_vld[5:0];
  assign gitid_valid = &gid_vld;
  assign match       = (&hsh_vld) && (hash_r == hash);  // Build hash check

endmodule

//--- rtl/mbox_dpram.sv
`timescale 1ns/10ps
module mbox_dpram (
  input  logic                      clk,
  input  mbox_map_pkg::mbox_addr_t  addr1,  // SPI side
  input  mbox_map_pkg::byte_t       din1,
  input  logic                      wen1,
  input  logic                      ren1,
  input  mbox_map_pkg::mbox_addr_t  addr2,  // Local bus side
  input  mbox_map_pkg::byte_t       din2,
  input  logic                      wen2,
  input  logic                      ren2,
  output mbox_map_pkg::byte_t       dout1,
  output mbox_map_pkg::byte_t       dout2
);

  localparam int depth = 2 ** $bits(mbox_map_pkg::mbox_addr_t);

  mbox_map_pkg::byte_t mem [depth];
  logic                contention;  // Both ports write one byte

  assign contention = wen1 && wen2 && (addr1 == addr2);

  always_ff @(posedge clk) begin
    if (wen1) mem[addr1] <= din1;
    if (wen2) mem[addr2] <= din2;
  end

  // Registered reads, output holds between reads
  always_ff @(posedge clk) begin
    if (ren1) dout1 <= mem[addr1];
  end

  always_ff @(posedge clk) begin
    if (ren2) dout2 <= mem[addr2];
  end

  no_write_clash: assert property (@(posedge clk) !contention)
    else $error("Mailbox write contention at %h", addr1);

endmodule

//--- rtl/mbox_map_pkg.sv
package mbox_map_pkg;

  // Mailbox is 128 pages of 16 bytes, 2 kB in all
  typedef logic [10:0] mbox_addr_t;  // {page, offset}
  typedef logic [6:0]  mbox_page_t;  // Set by the page select word
  typedef logic [3:0]  mbox_off_t;   // Low nibble of the SPI address byte

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word32_t;     // Git ID, build hash

  // Capture windows
  // Four bytes each, big-endian, MSB at the window offset
  localparam mbox_page_t gitid_page   = 7'd3;
  localparam mbox_off_t  gitid_offset = 4'd12;
  localparam mbox_page_t hash_page    = 7'd4;
  localparam mbox_off_t  hash_offset  = 4'd12;

endpackage

//--- rtl/mmc_mailbox.sv
`timescale 1ns/10ps
module mmc_mailbox #(
  parameter mbox_map_pkg::word32_t hash = '0,
  parameter logic default_enable_rx = 1'b1,
  parameter logic [127:0] udp_ports = {16'd0, 16'd0, 16'd0, 16'd0,
                                       16'd803, 16'd802, 16'd801, 16'd7}
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  mbox_map_pkg::mbox_addr_t   lb_addr,
  input  mbox_map_pkg::byte_t        lb_din,
  input  logic                       lb_write,
  input  logic                       lb_control_strobe,
  output mbox_map_pkg::byte_t        lb_dout,  // 2 clk after the read strobe
  input  logic                       sck,
  input  logic                       ncs,
  input  logic                       pico,
  output logic                       poci,
  output mbox_map_pkg::mbox_addr_t   mb_addr,
  output logic                       mb_wen,
  output logic                       mb_ren,
  output logic                       mb_strobe,  // Once per SPI word
  input  logic [2:0]                 pno_a,
  output logic [15:0]                pno_d,
  output logic                       enable_rx,
  output logic                       ip_valid,
  output mbox_map_pkg::word32_t      ip,
  output logic                       mac_valid,
  output logic [47:0]                mac,
  output logic                       gitid_valid,
  output mbox_map_pkg::word32_t      gitid,
  output logic                       match
);

  logic                       cfg_w;
  logic                       cfg_r;
  spi_cmd_pkg::cfg_addr_t     cfg_a;
  mbox_map_pkg::byte_t        cfg_d;
  mbox_map_pkg::byte_t        tx_data;  // Port-1 read data back to SPI
  mbox_map_pkg::mbox_page_t   page;
  logic                       lb_ren;

  // Port-1 controls, also visible outside
  assign mb_addr   = {page, cfg_a[3:0]};
  assign mb_wen    = cfg_w && (spi_cmd_pkg::cmd_group_e'(cfg_a[7:4]) ==
                               spi_cmd_pkg::grp_mb_write);
  assign mb_ren    = cfg_r;  // Already limited to grp_mb_read
  assign mb_strobe = cfg_w;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) lb_ren <= 1'b0;
    else lb_ren <= lb_control_strobe && !lb_write;  // Read request
  end

  spi_word_rx u_spi (
    .clk, .rst_n, .sck, .ncs, .pico, .tx_data,
    .poci, .cfg_w, .cfg_r, .cfg_a, .cfg_d
  );

  mbox_cfg_regs #(
    .hash              (hash),
    .default_enable_rx (default_enable_rx)
  ) u_cfg (
    .clk, .rst_n, .cfg_w, .cfg_a, .cfg_d,
    .page, .enable_rx, .ip_valid, .ip, .mac_valid, .mac,
    .gitid_valid, .gitid, .match
  );

  udp_port_table #(.udp_ports(udp_ports)) u_udp (
    .clk, .rst_n, .cfg_w, .cfg_a, .cfg_d, .pno_a, .pno_d
  );

  mbox_dpram u_mem (
    .clk   (clk),
    .addr1 (mb_addr),
    .din1  (cfg_d),
    .wen1  (mb_wen),
    .ren1  (mb_ren),
    .dout1 (tx_data),
    .addr2 (lb_addr),
    .din2  (lb_din),
    .wen2  (lb_write),  // Same-cycle write
    .ren2  (lb_ren),
    .dout2 (lb_dout)
  );

endmodule

//--- rtl/spi_cmd_pkg.sv
package spi_cmd_pkg;

  // One SPI transaction is one word, MSB first
  //   0001 aaaa dddddddd  IP/MAC byte a
  //   0010 0000 xxxxxxxV  enable_rx
  //   0010 0010 xddddddd  mailbox page select
  //   0011 aaaa dddddddd  UDP port table byte a
  //   0100 aaaa xxxxxxxx  mailbox read, data back on poci
  //   0101 aaaa dddddddd  mailbox write
  typedef logic [15:0] spi_word_t;
  typedef logic [7:0]  cfg_addr_t;  // Upper byte of the word

  typedef enum logic [3:0] {
    grp_ipmac    = 4'd1,
    grp_special  = 4'd2,
    grp_udp      = 4'd3,
    grp_mb_read  = 4'd4,
    grp_mb_write = 4'd5
  } cmd_group_e;

  // Full addresses inside grp_special
  localparam cfg_addr_t addr_enable_rx = 8'h20;
  localparam cfg_addr_t addr_page_sel  = 8'h22;

endpackage

//--- rtl/spi_word_rx.sv
`timescale 1ns/10ps
module spi_word_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    ncs,
  input  logic                    pico,
  input  mbox_map_pkg::byte_t     tx_data,  // Mailbox byte, one clk after cfg_r
  output logic                    poci,
  output logic                    cfg_w,
  output logic                    cfg_r,
  output spi_cmd_pkg::cfg_addr_t  cfg_a,
  output mbox_map_pkg::byte_t     cfg_d
);

  typedef enum logic [1:0] {st_idle, st_shift, st_done} state_e;

  state_e                  state;
  logic [2:0]              sck_sync;   // [1] synced, [2] previous
  logic [2:0]              ncs_sync;
  logic [1:0]              pico_sync;  // Same latency as sck_sync[1]
  logic                    sck_rise;
  logic                    sck_fall;
  logic                    ncs_rise;
  logic                    ncs_hi;
  logic [3:0]              bit_cnt;
  spi_cmd_pkg::spi_word_t  in_sr;
  spi_cmd_pkg::spi_word_t  in_next;
  mbox_map_pkg::byte_t     out_sr;
  logic                    load_pend;  // tx_data arrives this cycle

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign ncs_rise = ncs_sync[1] & ~ncs_sync[2];  // End of word
  assign ncs_hi   = ncs_sync[1];
  assign in_next  = {in_sr[14:0], pico_sync[1]};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync  <= '0;
      ncs_sync  <= '1;  // Deselected
      pico_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      ncs_sync  <= {ncs_sync[1:0], ncs};
      pico_sync <= {pico_sync[0], pico};
    end
  end

  // Sampled on sck rising edges
  always_ff @(posedge clk) begin
    if (sck_rise) in_sr <= in_next;
  end

  // Transaction sequencing, done lasts one clk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle:  if (!ncs_hi) state <= st_shift;
        st_shift: if (ncs_rise) state <= st_done;
        default:  state <= st_idle;
      endcase
    end
  end

  assign cfg_w = (state == st_done);  // Whole word on cfg_a/cfg_d

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt   <= '0;
      cfg_r     <= 1'b0;
      cfg_a     <= '0;
      cfg_d     <= '0;
      load_pend <= 1'b0;
      out_sr    <= '0;
      poci      <= 1'b0;
    end else begin
      cfg_r     <= 1'b0;
      load_pend <= cfg_r;  // Memory read latency
      if (ncs_hi) begin
        bit_cnt <= '0;
        out_sr  <= '0;  // Bits 0..7 go out as zero
        poci    <= 1'b0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 4'd1;
          // Address byte complete after the 8th bit
          if (bit_cnt == 4'd7 &&
              spi_cmd_pkg::cmd_group_e'(in_next[7:4]) == spi_cmd_pkg::grp_mb_read) begin
            cfg_r <= 1'b1;
            cfg_a <= in_next[7:0];
          end
        end
        if (load_pend) begin
          out_sr <= tx_data;  // Ahead of the 8th falling edge
        end else if (sck_fall) begin
          poci   <= out_sr[7];  // MSB first
          out_sr <= {out_sr[6:0], 1'b0};
        end
      end
      if (ncs_rise && state == st_shift) begin
        cfg_a <= in_sr[15:8];
        cfg_d <= in_sr[7:0];
      end
    end
  end

  // Read pulse comes mid-word, write pulse only after ncs rises
  w_r_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(cfg_w && cfg_r))
    else $error("cfg_w and cfg_r pulsed together");
  w_single: assert property (@(posedge clk) disable iff (!rst_n) cfg_w |=> !cfg_w)
    else $error("cfg_w longer than one clk");

endmodule

//--- rtl/udp_port_table.sv
`timescale 1ns/10ps
module udp_port_table #(
  parameter logic [127:0] udp_ports = '0  // Entry 0 in the low bits
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cfg_w,
  input  spi_cmd_pkg::cfg_addr_t  cfg_a,
  input  mbox_map_pkg::byte_t     cfg_d,
  input  logic [2:0]              pno_a,
  output logic [15:0]             pno_d
);

  logic [15:0] pno_mem [8];
  logic        udp_wr;

  assign udp_wr = cfg_w &&
                  (spi_cmd_pkg::cmd_group_e'(cfg_a[7:4]) == spi_cmd_pkg::grp_udp);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 8; i++) begin
        pno_mem[i] <= udp_ports[16*i +: 16];
      end
    end else if (udp_wr) begin
      // Entry from a[3:1], byte lane from a[0]
      if (cfg_a[0]) pno_mem[cfg_a[3:1]][15:8] <= cfg_d;
      else pno_mem[cfg_a[3:1]][7:0] <= cfg_d;
    end
  end

  assign pno_d = pno_mem[pno_a];  // Async lookup for the network side

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the mailbox testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mmc_mailbox_tb \
  -f mmc_mailbox.f -o sim_mmc_mailbox
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_mmc_mailbox > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
  exit 0
fi
exit 1
